//--- axi_burst_master.f
+incdir+.
axi_burst_master_pkg.sv
sync_fifo.sv
write_burst_engine.sv
read_burst_engine.sv
axi_burst_master.sv
axi_mem_model.sv
tb_clock_gen.sv
axi_burst_master_properties.sv
axi_burst_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the burst master testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f axi_burst_master.f --top-module axi_burst_master_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

# The log decides the result.
if grep -q "Simulation completed successfully" "$LOG"; then
  echo "Run passed"
  exit 0
fi
echo "Run failed"
exit 1

//--- axi_burst_master_tb.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

module axi_burst_master_tb
  import axi_burst_master_pkg::*;
();

  localparam int BP_READS   = 20;                  // More than both queues hold.
  localparam int N_REQ      = 2 + 40 + BP_READS;
  localparam int MAX_CYCLES = N_REQ * 80 + 200;

  logic       aclk;
  logic       aresetn;
  // Left side.
  ls_req_t    ls_req;
  logic       ls_valid_in;
  logic       ls_ready_out;
  logic       ls_valid_out;
  logic       ls_ready_in;
  line_t      ls_data_out;
  // AXI handshakes.
  logic       aw_valid;
  logic       aw_ready;
  logic       w_valid;
  logic       w_ready;
  logic       w_last;
  logic       b_valid;
  logic       b_ready;
  logic       ar_valid;
  logic       ar_ready;
  logic       r_valid;
  logic       r_ready;
  logic       r_last;
  // AXI payload and burst fields.
  addr_t      aw_addr;
  addr_t      ar_addr;
  addr_t      cap_addr;     // Address the slave took.
  logic [7:0] aw_len;
  logic [7:0] ar_len;
  logic [2:0] aw_size;
  logic [2:0] ar_size;
  logic [1:0] aw_burst;
  logic [1:0] ar_burst;
  logic [1:0] b_resp;
  axi_id_t    aw_id;
  axi_id_t    ar_id;
  word_t      w_data;
  word_t      r_data;
  logic [3:0] w_strb;
  logic [3:0] stall;        // Slave stall bits.
  logic       cap_valid;

  logic [15:0] data_lfsr  = 16'd75; // Stimulus stream.
  logic [15:0] stall_lfsr = 16'd75; // Slave stall stream.
  line_t       shadow [64];         // Reference copy of the memory, by line.
  line_t       exp_q [$];           // Expected read lines, in request order.
  addr_t       exp_addr_q [$];      // Expected burst addresses, in request order.
  int unsigned cycles = 0;

  tb_clock_gen u_clk (.aclk(aclk));
  axi_burst_master UUT (.*);
  axi_mem_model u_mem (.*);

  ////////////////////////////////////////////////////////////
  // Random source and reference.
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13, 11.
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      bits = {bits[30:0], data_lfsr[0]};
    end
  endtask

  task automatic rand_addr(output addr_t addr);
    logic [31:0] idx;
    draw_bits(6, idx);
    addr = 32'h8000_0000 | (idx << 5); // Line aligned.
  endtask

  task automatic rand_line(output line_t line);
    logic [31:0] word;
    for (int i = 0; i < `BURST_BEATS; i++) begin
      draw_bits(32, word);
      line[i * `AXI_DATA_W +: `AXI_DATA_W] = word;
    end
  endtask

  // Line content before this access; a write then replaces it.
  function automatic line_t ref_line(input logic op, input addr_t addr, input line_t line);
    line_t prior;
    prior = shadow[addr[10:5]];
    if (op) shadow[addr[10:5]] = line;
    return prior;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks.
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first failure.");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // Offer one request and wait for its handshake; returns 1 unit after that edge.
  task automatic send_req(input logic op, input addr_t addr, input line_t line);
    line_t prior;
    ls_req.op   = op;
    ls_req.addr = addr;
    ls_req.line = line;
    ls_valid_in = 1'b1;
    do @(negedge aclk); while (!ls_ready_out); // Ready is settled mid-cycle.
    @(posedge aclk);
    #1;
    ls_valid_in = 1'b0;
    prior = ref_line(op, addr, line);
    exp_addr_q.push_back(addr);
    if (!op) exp_q.push_back(prior);
  endtask

  // Waits up to limit cycles for ls_ready_out, with no request offered.
  task automatic wait_ready(input int limit, output logic seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge aclk);
      seen = ls_ready_out;
    end
    @(posedge aclk);
    #1;
  endtask

  always @(posedge aclk) begin
    #1;
    for (int i = 0; i < 4; i++) begin
      stall_lfsr = lfsr_next(stall_lfsr);
      stall[i] = stall_lfsr[0];
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d lines outstanding", cycles, exp_q.size());
      abort_run();
    end
  end

  // Returned lines, sampled mid-cycle ahead of their handshake edge.
  always @(negedge aclk) begin
    if (aresetn && ls_valid_out && ls_ready_in) begin
      if (exp_q.size() == 0) begin
        $display("A line came back with no read outstanding");
        abort_run();
      end else begin
        check_line("ls_data_out", ls_data_out, exp_q.pop_front());
      end
    end
  end

  always @(negedge aclk) begin
    if (aresetn && cap_valid) begin
      if (exp_addr_q.size() == 0) begin
        $display("The slave saw a burst that was never requested");
        abort_run();
      end else begin
        check_addr("cap_addr", cap_addr, exp_addr_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus.
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] bits;
    addr_t       addr;
    line_t       line;
    logic        room;
    logic        blocked;

    aresetn     = 1'b0;
    ls_req      = '0;
    ls_valid_in = 1'b0;
    ls_ready_in = 1'b1;
    stall       = '0;
    blocked     = 1'b0;
    for (int i = 0; i < 64; i++) shadow[i] = '0;
    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    @(negedge aclk);
    check_flag("ls_valid_out", ls_valid_out, 1'b0);
    check_flag("ls_ready_out", ls_ready_out, 1'b1);
    @(posedge aclk);
    #1;

    rand_addr(addr); // Write then read back one line.
    rand_line(line);
    send_req(1'b1, addr, line);
    send_req(1'b0, addr, '0);

    for (int n = 0; n < 40; n++) begin
      draw_bits(1, bits);
      rand_addr(addr);
      rand_line(line);
      send_req(bits[0], addr, line);
    end

    // Hold returns until the request queue backs up.
    ls_ready_in = 1'b0;
    for (int n = 0; n < BP_READS; n++) begin
      if (!blocked) begin
        wait_ready(100, room);
        if (!room) begin
          blocked     = 1'b1;
          ls_ready_in = 1'b1;
        end
      end
      rand_addr(addr);
      send_req(1'b0, addr, '0);
    end
    if (!blocked) begin
      $display("ls_ready_out never dropped while returns were held");
      abort_run();
    end

    while (exp_q.size() != 0) @(posedge aclk);
    if (exp_addr_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d bursts never reached the slave", exp_addr_q.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- axi_burst_master_properties.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// AXI-side checks on the burst master.
module axi_burst_master_properties
  import axi_burst_master_pkg::*;
(
  input logic       aclk,
  input logic       aresetn,
  input logic       aw_valid,
  input logic       aw_ready,
  input logic [7:0] aw_len,
  input logic [2:0] aw_size,
  input logic [1:0] aw_burst,
  input axi_id_t    aw_id,
  input logic       w_valid,
  input logic       w_ready,
  input logic [3:0] w_strb,
  input logic       w_last,
  input logic       b_ready,
  input logic       ar_valid,
  input logic       ar_ready,
  input logic [7:0] ar_len,
  input logic [2:0] ar_size,
  input logic [1:0] ar_burst,
  input axi_id_t    ar_id,
  input logic       r_ready,
  input logic       wr_idle,
  input logic       rd_idle
);

  beat_idx_t w_cnt; // W beats taken in the current burst, wraps at eight.

  always @(posedge aclk) begin
    if (!aresetn) w_cnt <= '0;
    else if (w_valid && w_ready) w_cnt <= w_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Reset and handshake rules.
  ////////////////////////////////////////////////////////////
  a_reset_quiet: assert property (@(posedge aclk)
    !aresetn |=> !(aw_valid || w_valid || ar_valid || b_ready || r_ready))
    else $error("AXI valid or ready active during reset");
  a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid && !aw_ready |=> aw_valid) else $error("aw_valid dropped before aw_ready");
  a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid && !w_ready |=> w_valid) else $error("w_valid dropped before w_ready");
  a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    ar_valid && !ar_ready |=> ar_valid) else $error("ar_valid dropped before ar_ready");
  a_one_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_idle || rd_idle) else $error("Write and read engines busy together");

  ////////////////////////////////////////////////////////////
  // Burst form.
  ////////////////////////////////////////////////////////////
  a_aw_form: assert property (@(posedge aclk) disable iff (!aresetn)
    aw_valid |-> aw_len == 8'd7 && aw_size == 3'd2 && aw_burst == 2'b01 && aw_id == '0)
    else $error("Bad AW burst fields");
  a_ar_form: assert property (@(posedge aclk) disable iff (!aresetn)
    ar_valid |-> ar_len == 8'd7 && ar_size == 3'd2 && ar_burst == 2'b01 && ar_id == '0)
    else $error("Bad AR burst fields");
  a_w_strb: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid |-> &w_strb) else $error("W strobes not all set");
  a_w_last: assert property (@(posedge aclk) disable iff (!aresetn)
    w_valid |-> (w_last == (w_cnt == 3'd7))) else $error("w_last not on the eighth beat");

endmodule

bind axi_burst_master axi_burst_master_properties u_props (.*);

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

// Free-running testbench clock.
module tb_clock_gen (
  output logic aclk
);

  initial aclk = 1'b0;

  always #2 aclk = ~aclk; // Half of the 4-unit period.

endmodule

`default_nettype wire

//--- axi_mem_model.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// AXI4 slave over a 64-line memory; stall bits gate the ready and valid outputs.
module axi_mem_model
  import axi_burst_master_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic [3:0] stall,      // Random bits: AW, W, AR ready and R valid.
  input  logic       aw_valid,
  output logic       aw_ready,
  input  addr_t      aw_addr,
  input  logic       w_valid,
  output logic       w_ready,
  input  word_t      w_data,
  input  logic       w_last,
  output logic       b_valid,
  input  logic       b_ready,
  output logic [1:0] b_resp,
  input  logic       ar_valid,
  output logic       ar_ready,
  input  addr_t      ar_addr,
  output logic       r_valid,
  input  logic       r_ready,
  output word_t      r_data,
  output logic       r_last,
  output logic       cap_valid,  // High for one cycle after an AW or AR handshake.
  output addr_t      cap_addr    // Address taken on that handshake.
);

  word_t      mem [64 * `BURST_BEATS]; // Line index, then beat.
  logic [5:0] wr_line;
  beat_idx_t  wr_beat;
  logic [5:0] rd_line;
  beat_idx_t  rd_beat;
  logic       rd_busy;                 // Between AR and the last R beat.

  initial begin
    for (int i = 0; i < 64 * `BURST_BEATS; i++) mem[i] = '0; // Unwritten lines read as zero.
  end

  assign aw_ready = stall[0];
  assign w_ready  = stall[1];
  assign ar_ready = stall[2];
  assign b_resp   = 2'b00;                 // Always OKAY.
  assign r_data   = mem[{rd_line, rd_beat}];
  assign r_last   = (rd_beat == beat_idx_t'(`BURST_BEATS - 1));

  always @(posedge aclk) begin
    if (!aresetn) begin
      wr_beat   <= '0;
      rd_beat   <= '0;
      rd_busy   <= 1'b0;
      r_valid   <= 1'b0;
      b_valid   <= 1'b0;
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= 1'b0;
      if (aw_valid && aw_ready) begin
        wr_line   <= aw_addr[10:5];        // Line select, aliased over 64 lines.
        wr_beat   <= '0;
        cap_valid <= 1'b1;
        cap_addr  <= aw_addr;
      end
      if (w_valid && w_ready) begin
        mem[{wr_line, wr_beat}] <= w_data;
        wr_beat <= wr_beat + 1'b1;
        if (w_last) b_valid <= 1'b1;       // Respond once the burst is in.
      end
      if (b_valid && b_ready) b_valid <= 1'b0;
      if (ar_valid && ar_ready) begin
        rd_line   <= ar_addr[10:5];
        rd_beat   <= '0;
        rd_busy   <= 1'b1;
        cap_valid <= 1'b1;
        cap_addr  <= ar_addr;
      end
      // R valid rises on a stall bit and is held until taken.
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
        rd_beat <= rd_beat + 1'b1;
        if (r_last) rd_busy <= 1'b0;
      end else if (rd_busy && !r_valid && stall[3]) begin
        r_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- axi_burst_master.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// Valid/ready line requests in, one AXI4 burst at a time out.
module axi_burst_master
  import axi_burst_master_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,
  // Left-side request channel.
  input  ls_req_t                  ls_req,
  input  logic                     ls_valid_in,
  output logic                     ls_ready_out,
  // Left-side return channel.
  output line_t                    ls_data_out,
  output logic                     ls_valid_out,
  input  logic                     ls_ready_in,
  // AW channel.
  output logic                     aw_valid,
  input  logic                     aw_ready,
  output addr_t                    aw_addr,
  output logic [7:0]               aw_len,
  output logic [2:0]               aw_size,
  output logic [1:0]               aw_burst,
  output axi_id_t                  aw_id,
  // W channel.
  output logic                     w_valid,
  input  logic                     w_ready,
  output word_t                    w_data,
  output logic [`AXI_DATA_W/8-1:0] w_strb,
  output logic                     w_last,
  // B channel; the response code is accepted but not decoded.
  input  logic                     b_valid,
  output logic                     b_ready,
  input  logic [1:0]               b_resp,
  // AR channel.
  output logic                     ar_valid,
  input  logic                     ar_ready,
  output addr_t                    ar_addr,
  output logic [7:0]               ar_len,
  output logic [2:0]               ar_size,
  output logic [1:0]               ar_burst,
  output axi_id_t                  ar_id,
  // R channel.
  input  logic                     r_valid,
  output logic                     r_ready,
  input  word_t                    r_data,
  input  logic                     r_last
);

  localparam logic [1:0] BURST_INCR = 2'b01;

  ls_req_t req_head;   // Show-ahead head of the request queue.
  logic    req_full;
  logic    req_empty;
  logic    req_pop;
  logic    ret_push;
  line_t   ret_line;
  logic    ret_full;
  logic    ret_empty;
  logic    wr_start;
  logic    rd_start;
  logic    wr_taken;
  logic    rd_taken;
  logic    wr_idle;
  logic    rd_idle;
  logic    bus_free;

  ////////////////////////////////////////////////////////////
  // Fixed burst fields.
  ////////////////////////////////////////////////////////////
  assign aw_len   = 8'(`BURST_BEATS - 1);
  assign ar_len   = 8'(`BURST_BEATS - 1);
  assign aw_size  = 3'($clog2(`AXI_DATA_W / 8)); // Full-width beats.
  assign ar_size  = 3'($clog2(`AXI_DATA_W / 8));
  assign aw_burst = BURST_INCR;
  assign ar_burst = BURST_INCR;
  assign aw_id    = axi_id_t'(`MASTER_ID);
  assign ar_id    = axi_id_t'(`MASTER_ID);
  assign w_strb   = '1;

  ////////////////////////////////////////////////////////////
  // Dispatch. One transaction on the bus at a time.
  ////////////////////////////////////////////////////////////
  assign bus_free = wr_idle & rd_idle & ~req_empty;
  assign wr_start = bus_free & req_head.op;
  assign rd_start = bus_free & ~req_head.op & ~ret_full; // Reserve a return slot.
  assign req_pop  = wr_taken | rd_taken;                  // Pop on the address handshake.

  assign ls_ready_out = ~req_full;
  assign ls_valid_out = ~ret_empty;

  sync_fifo #(.entry_t(ls_req_t)) req_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .push     (ls_valid_in & ls_ready_out),
    .data_in  (ls_req),
    .full     (req_full),
    .pop      (req_pop),
    .data_out (req_head),
    .empty    (req_empty)
  );

  sync_fifo #(.entry_t(line_t)) ret_fifo (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .push     (ret_push),
    .data_in  (ret_line),
    .full     (ret_full),
    .pop      (ls_valid_out & ls_ready_in),
    .data_out (ls_data_out),
    .empty    (ret_empty)
  );

  write_burst_engine u_wr_engine (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .wr_start  (wr_start),
    .req       (req_head),
    .req_taken (wr_taken),
    .idle      (wr_idle),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .aw_addr   (aw_addr),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w_data    (w_data),
    .w_last    (w_last),
    .b_valid   (b_valid),
    .b_ready   (b_ready)
  );

  read_burst_engine u_rd_engine (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .rd_start  (rd_start),
    .req_addr  (req_head.addr),
    .req_taken (rd_taken),
    .idle      (rd_idle),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar_addr   (ar_addr),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r_data    (r_data),
    .r_last    (r_last),
    .ret_push  (ret_push),
    .ret_line  (ret_line)
  );

endmodule

`default_nettype wire

//--- read_burst_engine.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// One INCR read burst per start: AR, eight R beats, then one line push.
module read_burst_engine
  import axi_burst_master_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  // Dispatcher side.
  input  logic  rd_start,   // Head is a read, bus free, return slot free.
  input  addr_t req_addr,
  output logic  req_taken,  // Pulses on the AR handshake.
  output logic  idle,
  // AR channel.
  output logic  ar_valid,
  input  logic  ar_ready,
  output addr_t ar_addr,
  // R channel.
  input  logic  r_valid,
  output logic  r_ready,
  input  word_t r_data,
  input  logic  r_last,
  // Return queue.
  output logic  ret_push,
  output line_t ret_line
);

  rd_state_e state_q;  // Burst phase.
  addr_t     addr_q;   // Latched burst address.
  line_t     line_q;   // Line being assembled.
  beat_idx_t beat_q;   // Slot for the next R beat.
  logic      ar_hs;
  logic      r_hs;

  assign ar_valid = (state_q == RD_ADDR);
  assign r_ready  = (state_q == RD_DATA); // Slot was reserved before issue.
  assign ret_push = (state_q == RD_PUSH); // One cycle after the last beat.
  assign idle     = (state_q == RD_IDLE);

  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  assign req_taken = ar_hs;
  assign ar_addr   = addr_q;
  assign ret_line  = line_q;

  ////////////////////////////////////////////////////////////
  // Burst FSM.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= RD_IDLE;
      beat_q  <= '0;
    end else begin
      unique case (state_q)
        RD_IDLE: begin
          if (rd_start) begin
            state_q <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (ar_hs) begin
            state_q <= RD_DATA;
            beat_q  <= '0;
          end
        end
        RD_DATA: begin
          if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (r_last) begin
              state_q <= RD_PUSH; // Line is complete after this edge.
            end
          end
        end
        RD_PUSH: state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // Address capture on start, beat capture on each R handshake.
  always_ff @(posedge aclk) begin
    if (idle && rd_start) begin
      addr_q <= req_addr;
    end
    if (r_hs) begin
      line_q[beat_q * `AXI_DATA_W +: `AXI_DATA_W] <= r_data; // Word 0 lands low.
    end
  end

endmodule

`default_nettype wire

//--- write_burst_engine.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// One INCR write burst per start: AW, eight W beats, then B.
module write_burst_engine
  import axi_burst_master_pkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  // Dispatcher side.
  input  logic    wr_start,   // Head is a write and the bus is free.
  input  ls_req_t req,        // Head request, sampled on wr_start.
  output logic    req_taken,  // Pulses on the AW handshake.
  output logic    idle,
  // AW channel.
  output logic    aw_valid,
  input  logic    aw_ready,
  output addr_t   aw_addr,
  // W channel.
  output logic    w_valid,
  input  logic    w_ready,
  output word_t   w_data,
  output logic    w_last,
  // B channel.
  input  logic    b_valid,
  output logic    b_ready
);

  localparam beat_idx_t LAST_BEAT = beat_idx_t'(`BURST_BEATS - 1);

  wr_state_e state_q;  // Burst phase.
  addr_t     addr_q;   // Latched burst address.
  line_t     line_q;   // Latched write line.
  beat_idx_t beat_q;   // Word being offered on W.
  logic      aw_hs;
  logic      w_hs;
  logic      b_hs;

  ////////////////////////////////////////////////////////////
  // Channel outputs, all decoded from the state.
  ////////////////////////////////////////////////////////////
  assign aw_valid = (state_q == WR_ADDR);
  assign w_valid  = (state_q == WR_DATA);
  assign b_ready  = (state_q == WR_RESP);
  assign idle     = (state_q == WR_IDLE);

  assign aw_hs = aw_valid & aw_ready;
  assign w_hs  = w_valid & w_ready;
  assign b_hs  = b_valid & b_ready;

  assign req_taken = aw_hs;   // Dispatcher pops the head here.
  assign aw_addr   = addr_q;

  // Beat select, word 0 first.
  assign w_data = line_q[beat_q * `AXI_DATA_W +: `AXI_DATA_W];
  assign w_last = (beat_q == LAST_BEAT); // Only seen while w_valid is high.

  ////////////////////////////////////////////////////////////
  // Burst FSM.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= WR_IDLE;
      beat_q  <= '0;
    end else begin
      unique case (state_q)
        WR_IDLE: begin
          if (wr_start) begin
            state_q <= WR_ADDR;  // aw_valid rises next cycle.
          end
        end
        WR_ADDR: begin
          if (aw_hs) begin
            state_q <= WR_DATA;
            beat_q  <= '0;       // Start from word 0.
          end
        end
        WR_DATA: begin
          if (w_hs) begin
            beat_q <= beat_q + 1'b1;
            if (w_last) begin
              state_q <= WR_RESP; // Wait for B.
            end
          end
        end
        WR_RESP: begin
          if (b_hs) begin
            state_q <= WR_IDLE;  // Response itself is not decoded.
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  // Payload capture, only when a new burst starts.
  always_ff @(posedge aclk) begin
    if (idle && wr_start) begin
      addr_q <= req.addr;
      line_q <= req.line;
    end
  end

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

// Circular buffer with a count; head is visible on data_out without delay.
module sync_fifo #(
  parameter type entry_t = logic
) (
  input  logic   aclk,
  input  logic   aresetn,
  input  logic   push,      // Write data_in at the tail.
  input  entry_t data_in,
  output logic   full,
  input  logic   pop,       // Drop the head entry.
  output entry_t data_out,
  output logic   empty
);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t             mem [DEPTH];  // Storage.
  logic [PTR_W-1:0]   wr_ptr;       // Next free slot.
  logic [PTR_W-1:0]   rd_ptr;       // Head slot.
  logic [CNT_W-1:0]   count;        // Entries held.
  logic               do_push;
  logic               do_pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // Out-of-range requests are dropped here.
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign data_out = mem[rd_ptr]; // Show-ahead head.

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at the end.
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop); // Both at once leaves it unchanged.
    end
  end

endmodule

`default_nettype wire

//--- axi_burst_master_pkg.sv
`default_nettype none
`include "axi_burst_master_macros.svh"

package axi_burst_master_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types.
  ////////////////////////////////////////////////////////////
  typedef logic [`AXI_ADDR_W-1:0]           addr_t;     // Byte address.
  typedef logic [`AXI_DATA_W-1:0]           word_t;     // One AXI beat.
  typedef logic [`LINE_W-1:0]               line_t;     // One line, word 0 in the low bits.
  typedef logic [`AXI_ID_W-1:0]             axi_id_t;   // AxID value.
  typedef logic [$clog2(`BURST_BEATS)-1:0]  beat_idx_t; // Beat within a burst.

  // Left-side request, as queued in the request FIFO.
  typedef struct packed {
    logic  op;    // 1 = line write, 0 = line read.
    addr_t addr;  // Start address of the burst.
    line_t line;  // Write payload; don't care for a read.
  } ls_req_t;

  ////////////////////////////////////////////////////////////
  // Engine state machines.
  ////////////////////////////////////////////////////////////

  // Write engine: AW, then eight W beats, then B.
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Read engine: AR, then eight R beats, then one push of the line.
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_PUSH
  } rd_state_e;

endpackage

`default_nettype wire

//--- axi_burst_master_macros.svh
`ifndef AXI_BURST_MASTER_MACROS_SVH
`define AXI_BURST_MASTER_MACROS_SVH

// AXI address and beat widths.
`define AXI_ADDR_W   32
`define AXI_DATA_W   32

// Left-side line, one full burst wide.
`define LINE_W       256

// Transaction ID width and the single ID this master drives.
`define AXI_ID_W     4
`define MASTER_ID    0

// Beats per burst; AxLEN is one less.
`define BURST_BEATS  8

// Entries in both the request and the return queue.
`define FIFO_DEPTH   8

`endif
